// File: source/board_pkg.sv
`default_nettype none

package board_pkg;

    localparam int N_SWITCHES = 10;
    localparam int N_KEYS     = 2;
    localparam int N_LEDS     = 10;
    localparam int N_DIGITS   = 6;

    // cycles an input must hold before the debounced level follows it.
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES);

    localparam int TICK_DIV_FAST = 4;   // rate_sel 0.
    localparam int TICK_DIV_MID  = 16;  // rate_sel 1.
    localparam int TICK_DIV_SLOW = 64;  // rate_sel 2 and 3.
    localparam int TICK_CNT_W    = $clog2(TICK_DIV_SLOW);

    typedef logic [N_SWITCHES-1:0]     sw_t;
    typedef logic [N_KEYS-1:0]         key_t;
    typedef logic [N_LEDS-1:0]         led_t;
    typedef logic [3:0]                nibble_t;
    typedef logic [4*N_DIGITS-1:0]     hex_value_t;   // digit 0 in the low nibble.
    typedef logic [N_DIGITS-1:0]       digit_mask_t;
    typedef logic [7:0]                segments_t;    // dot, g..a, all active low.
    typedef logic [1:0]                rate_sel_t;
    typedef logic [DEBOUNCE_CNT_W-1:0] debounce_cnt_t;
    typedef logic [TICK_CNT_W-1:0]     tick_cnt_t;

endpackage

`default_nettype wire

// File: source/bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef logic [7:0]  bus_addr_t;   // byte address.
    typedef logic [31:0] bus_data_t;

    // register map, word aligned.
    localparam bus_addr_t REG_SWITCHES   = 8'h00;  // ro.
    localparam bus_addr_t REG_KEYS       = 8'h04;  // ro, pressed reads 1.
    localparam bus_addr_t REG_LEDS       = 8'h08;
    localparam bus_addr_t REG_HEX_VALUE  = 8'h0C;
    localparam bus_addr_t REG_HEX_CTRL   = 8'h10;
    localparam bus_addr_t REG_TICK_COUNT = 8'h14;  // any write clears.

    // field offsets inside REG_HEX_CTRL.
    localparam int HEX_BLANK_LSB = 0;
    localparam int HEX_DOT_LSB   = 8;
    localparam int HEX_BLINK_LSB = 16;

endpackage

`default_nettype wire

// File: source/display_if.sv
`timescale 1ns/1ps
`default_nettype none

interface display_if import board_pkg::*; ();

    hex_value_t  hex_value;
    digit_mask_t blank;
    digit_mask_t dots;
    digit_mask_t blink;

    modport ctrl (
        output hex_value,
        output blank,
        output dots,
        output blink
    );

    modport display (
        input hex_value,
        input blank,
        input dots,
        input blink
    );

endinterface

`default_nettype wire

// File: source/io_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module io_ctrl import board_pkg::*, bus_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire bus_addr_t bus_addr,
    input  wire bus_data_t bus_wdata,
    input  wire logic      bus_write,
    output bus_data_t      bus_rdata,
    input  wire sw_t       sw_db,
    input  wire key_t      key_db,
    input  wire logic      tick,
    output led_t           ledr,
    display_if.ctrl        disp
);

    led_t        led_q, led_d;
    hex_value_t  hex_value_q, hex_value_d;
    digit_mask_t blank_q, blank_d;
    digit_mask_t dots_q, dots_d;
    digit_mask_t blink_q, blink_d;
    bus_data_t   count_q, count_d;
    bus_data_t   rdata_q, rdata_d;
    key_t        key_pressed;

    assign key_pressed = ~key_db;  // keys are active low on the board.

    // next state of the writable registers.
    always_comb begin
        led_d       = led_q;
        hex_value_d = hex_value_q;
        blank_d     = blank_q;
        dots_d      = dots_q;
        blink_d     = blink_q;
        count_d     = count_q;
        if (tick) begin
            count_d = count_q + 1'b1;
        end
        if (bus_write) begin
            case (bus_addr)
                REG_LEDS:       led_d       = led_t'(bus_wdata);
                REG_HEX_VALUE:  hex_value_d = hex_value_t'(bus_wdata);
                REG_HEX_CTRL: begin
                    blank_d = bus_wdata[HEX_BLANK_LSB +: N_DIGITS];
                    dots_d  = bus_wdata[HEX_DOT_LSB +: N_DIGITS];
                    blink_d = bus_wdata[HEX_BLINK_LSB +: N_DIGITS];
                end
                REG_TICK_COUNT: count_d     = '0;  // clear wins over a tick.
                default: ;
            endcase
        end
    end

    // read word sees a write made at the same edge.
    always_comb begin
        rdata_d = '0;
        case (bus_addr)
            REG_SWITCHES:   rdata_d = bus_data_t'(sw_db);
            REG_KEYS:       rdata_d = bus_data_t'(key_pressed);
            REG_LEDS:       rdata_d = bus_data_t'(led_d);
            REG_HEX_VALUE:  rdata_d = bus_data_t'(hex_value_d);
            REG_HEX_CTRL: begin
                rdata_d[HEX_BLANK_LSB +: N_DIGITS] = blank_d;
                rdata_d[HEX_DOT_LSB +: N_DIGITS]   = dots_d;
                rdata_d[HEX_BLINK_LSB +: N_DIGITS] = blink_d;
            end
            REG_TICK_COUNT: rdata_d = count_d;
            default:        rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led_q       <= '0;
            hex_value_q <= '0;
            blank_q     <= '0;
            dots_q      <= '0;
            blink_q     <= '0;
            count_q     <= '0;
            rdata_q     <= '0;
        end else begin
            led_q       <= led_d;
            hex_value_q <= hex_value_d;
            blank_q     <= blank_d;
            dots_q      <= dots_d;
            blink_q     <= blink_d;
            count_q     <= count_d;
            rdata_q     <= rdata_d;
        end
    end

    assign bus_rdata      = rdata_q;
    assign ledr           = led_q;
    assign disp.hex_value = hex_value_q;
    assign disp.blank     = blank_q;
    assign disp.dots      = dots_q;
    assign disp.blink     = blink_q;

endmodule

`default_nettype wire

// File: source/input_debouncer.sv
`timescale 1ns/1ps
`default_nettype none

module input_debouncer import board_pkg::*; #(
    parameter int WIDTH = 1
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [WIDTH-1:0]  raw,
    output logic      [WIDTH-1:0]  clean
);

    logic [WIDTH-1:0] sync1_q;
    logic [WIDTH-1:0] sync2_q;
    debounce_cnt_t    cnt_q [WIDTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= raw;      // first stage may go metastable.
            sync2_q <= sync1_q;
        end
    end

    // one stability counter per bit.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clean <= '0;
            for (int i = 0; i < WIDTH; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (sync2_q[i] == clean[i]) begin
                    cnt_q[i] <= '0;  // level agrees, nothing pending.
                end else if (cnt_q[i] == debounce_cnt_t'(DEBOUNCE_CYCLES - 1)) begin
                    clean[i] <= sync2_q[i];
                    cnt_q[i] <= '0;
                end else begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/tick_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tick_divider import board_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire rate_sel_t rate_sel,
    output logic           tick
);

    tick_cnt_t cnt_q;
    tick_cnt_t div_m1;  // selected divisor minus one.

    always_comb begin
        case (rate_sel)
            2'd0:    div_m1 = tick_cnt_t'(TICK_DIV_FAST - 1);
            2'd1:    div_m1 = tick_cnt_t'(TICK_DIV_MID - 1);
            default: div_m1 = tick_cnt_t'(TICK_DIV_SLOW - 1);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
            tick  <= 1'b0;
        end else if (cnt_q >= div_m1) begin
            cnt_q <= '0;   // also catches a switch to a shorter divisor.
            tick  <= 1'b1;
        end else begin
            cnt_q <= cnt_q + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display import board_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  tick,
    display_if.display disp,
    output segments_t  hex0,
    output segments_t  hex1,
    output segments_t  hex2,
    output segments_t  hex3,
    output segments_t  hex4,
    output segments_t  hex5
);

    logic      blink_phase;
    segments_t seg_d [N_DIGITS];
    segments_t seg_q [N_DIGITS];

    // segments g..a, active low.
    function automatic logic [6:0] glyph(input nibble_t value);
        case (value)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'hA: return 7'b0001000;
            4'hB: return 7'b0000011;
            4'hC: return 7'b1000110;
            4'hD: return 7'b0100001;
            4'hE: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blink_phase <= 1'b0;
        end else if (tick) begin
            blink_phase <= ~blink_phase;
        end
    end

    always_comb begin
        for (int i = 0; i < N_DIGITS; i++) begin
            seg_d[i] = {~disp.dots[i], glyph(disp.hex_value[4*i +: 4])};
            if (disp.blank[i] || (disp.blink[i] && blink_phase)) begin
                seg_d[i] = '1;  // digit dark.
            end
        end
    end

    always_ff @(posedge clk) begin
        seg_q <= seg_d;
    end

    assign hex0 = seg_q[0];
    assign hex1 = seg_q[1];
    assign hex2 = seg_q[2];
    assign hex3 = seg_q[3];
    assign hex4 = seg_q[4];
    assign hex5 = seg_q[5];

endmodule

`default_nettype wire

// File: source/de10_lite_io.sv
`timescale 1ns/1ps
`default_nettype none

module de10_lite_io import board_pkg::*, bus_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire sw_t       sw,
    input  wire key_t      key,        // active low.
    output led_t           ledr,
    output segments_t      hex0,
    output segments_t      hex1,
    output segments_t      hex2,
    output segments_t      hex3,
    output segments_t      hex4,
    output segments_t      hex5,
    input  wire bus_addr_t bus_addr,
    input  wire bus_data_t bus_wdata,
    input  wire logic      bus_write,
    output bus_data_t      bus_rdata
);

    sw_t  sw_db;
    key_t key_db;
    logic tick;

    display_if disp0 ();

    input_debouncer #(.WIDTH(N_SWITCHES)) sw_debouncer0 (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   (sw),
        .clean (sw_db)
    );

    input_debouncer #(.WIDTH(N_KEYS)) key_debouncer0 (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   (key),
        .clean (key_db)
    );

    // two low switches pick the tick rate.
    tick_divider tick_divider0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .rate_sel (sw_db[1:0]),
        .tick     (tick)
    );

    io_ctrl io_ctrl0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_write (bus_write),
        .bus_rdata (bus_rdata),
        .sw_db     (sw_db),
        .key_db    (key_db),
        .tick      (tick),
        .ledr      (ledr),
        .disp      (disp0)
    );

    hex_display hex_display0 (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .disp  (disp0),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex2  (hex2),
        .hex3  (hex3),
        .hex4  (hex4),
        .hex5  (hex5)
    );

endmodule

`default_nettype wire

// File: dv/tb_de10_lite_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_de10_lite_io import board_pkg::*, bus_pkg::*; ();

    localparam int unsigned SEED         = 32'h2f47_79e0;
    localparam int          SETTLE_LIMIT = 12;  // reads allowed for a debounced level.
    localparam int          RATE_CYCLES  = 256;
    localparam int          BLINK_CYCLES = 48;

    logic        clk;
    logic        rst_n;
    sw_t         sw;
    key_t        key;
    led_t        ledr;
    segments_t   hex0, hex1, hex2, hex3, hex4, hex5;
    bus_addr_t   bus_addr;
    bus_data_t   bus_wdata;
    logic        bus_write;
    bus_data_t   bus_rdata;
    logic [47:0] hex_all;
    segments_t   glyphs [16];
    led_t        led_model;
    int          errors;
    int          timeouts;

    assign hex_all = {hex5, hex4, hex3, hex2, hex1, hex0};

    de10_lite_io dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .sw        (sw),
        .key       (key),
        .ledr      (ledr),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_write (bus_write),
        .bus_rdata (bus_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (bus_write && bus_addr == REG_LEDS) begin
            led_model <= bus_wdata[N_LEDS-1:0];
        end
    end

    // ledr shows the written bits right after the write edge.
    led_write_a: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_write && bus_addr == REG_LEDS) |=> (ledr == led_model))
    else begin
        errors++;
        $display("error led_write: expected %h, actual %h",
                 $sampled(led_model), $sampled(ledr));
    end

    task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
        bus_addr  = addr;
        bus_wdata = data;
        bus_write = 1'b1;
        @(posedge clk);
        #1;
        bus_write = 1'b0;
    endtask

    task automatic read_reg(input bus_addr_t addr, output bus_data_t data);
        bus_addr  = addr;
        bus_write = 1'b0;
        @(posedge clk);
        #1;
        data = bus_rdata;
    endtask

    task automatic check_value(input string name, input bus_data_t expected,
                               input bus_data_t actual);
        assert (actual === expected) else begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_for_reg(input string name, input bus_addr_t addr,
                                input bus_data_t expected);
        bus_data_t value;
        int        polls;
        polls = 0;
        do begin
            read_reg(addr, value);
            polls++;
        end while (value !== expected && polls < SETTLE_LIMIT);
        if (value !== expected) begin
            timeouts++;
            $display("timeout: %s did not settle within %0d reads", name, SETTLE_LIMIT);
        end
        check_value(name, expected, value);
    endtask

    function automatic int divisor_for(input rate_sel_t rate);
        case (rate)
            2'd0:    return TICK_DIV_FAST;
            2'd1:    return TICK_DIV_MID;
            default: return TICK_DIV_SLOW;
        endcase
    endfunction

    // blank in 5..0, dots in 13..8, blink in 21..16.
    function automatic bus_data_t ctrl_word(input digit_mask_t blank, input digit_mask_t dots,
                                            input digit_mask_t blink);
        return {10'b0, blink, 2'b0, dots, 2'b0, blank};
    endfunction

    function automatic segments_t expected_digit(input hex_value_t value,
                                                 input digit_mask_t dark,
                                                 input digit_mask_t dots, input int d);
        segments_t seg;
        seg    = glyphs[value[4*d +: 4]];
        seg[7] = ~dots[d];
        if (dark[d]) begin
            seg = 8'hFF;
        end
        return seg;
    endfunction

    task automatic check_display(input string name, input hex_value_t value,
                                 input digit_mask_t dark, input digit_mask_t dots);
        for (int d = 0; d < N_DIGITS; d++) begin
            check_value($sformatf("%s digit %0d", name, d),
                        bus_data_t'(expected_digit(value, dark, dots, d)),
                        bus_data_t'(hex_all[8*d +: 8]));
        end
    endtask

    initial begin
        bus_data_t   data;
        bus_data_t   wdata;
        bus_data_t   mask;
        bus_addr_t   addr;
        bus_addr_t   unmapped [4];
        sw_t         pattern;
        hex_value_t  value;
        digit_mask_t blank;
        digit_mask_t dots;
        digit_mask_t dark;
        segments_t   prev;
        segments_t   seg;
        int          count;
        int          expected;
        int          digit;
        int          changes;
        int          last_change;

        clk       = 1'b0;
        rst_n     = 1'b0;
        sw        = '0;
        key       = '1;  // released.
        bus_addr  = '0;
        bus_wdata = '0;
        bus_write = 1'b0;
        led_model = '0;
        errors    = 0;
        timeouts  = 0;
        glyphs    = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                      8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};
        unmapped  = '{8'h02, 8'h18, 8'h40, 8'hFC};
        data      = $urandom(SEED);
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_value("reset_ledr", '0, bus_data_t'(ledr));
        check_value("reset_rdata", '0, bus_rdata);
        read_reg(REG_SWITCHES, data);
        check_value("reset_switches", '0, data);
        read_reg(REG_LEDS, data);
        check_value("reset_leds", '0, data);
        read_reg(REG_HEX_VALUE, data);
        check_value("reset_hex_value", '0, data);
        read_reg(REG_HEX_CTRL, data);
        check_value("reset_hex_ctrl", '0, data);
        read_reg(REG_TICK_COUNT, data);
        wait_for_reg("reset_keys", REG_KEYS, '0);
        check_display("reset_display", '0, '0, '0);

        for (int i = 0; i < 12; i++) begin
            case ($urandom_range(2))
                0: begin
                    addr = REG_LEDS;
                    mask = 32'h0000_03FF;
                end
                1: begin
                    addr = REG_HEX_VALUE;
                    mask = 32'h00FF_FFFF;
                end
                default: begin
                    addr = REG_HEX_CTRL;
                    mask = 32'h003F_3F3F;  // blink, dot and blank fields.
                end
            endcase
            wdata = $urandom;
            write_reg(addr, wdata);
            if (addr == REG_LEDS) begin
                check_value("led_output", wdata & mask, bus_data_t'(ledr));
            end
            read_reg(addr, data);
            check_value("readback", wdata & mask, data);
        end
        foreach (unmapped[i]) begin
            write_reg(unmapped[i], $urandom);
            read_reg(unmapped[i], data);
            check_value("unmapped", '0, data);
        end

        for (int i = 0; i < 4; i++) begin
            pattern = sw ^ sw_t'($urandom | 1);  // at least bit 0 flips.
            sw      = pattern;
            wait_for_reg("switch_settle", REG_SWITCHES, bus_data_t'(pattern));
        end
        sw = ~pattern;
        for (int i = 0; i < 3 + 2 * DEBOUNCE_CYCLES; i++) begin
            if (i == 3) begin
                sw = pattern;  // glitch lasted three cycles.
            end
            read_reg(REG_SWITCHES, data);
            check_value("switch_glitch", bus_data_t'(pattern), data);
        end

        key = 2'b01;  // hold key 1.
        wait_for_reg("key_press", REG_KEYS, 32'd2);
        key = 2'b11;
        wait_for_reg("key_release", REG_KEYS, 32'd0);

        for (int rate = 0; rate < 4; rate++) begin
            pattern      = sw;
            pattern[1:0] = rate_sel_t'(rate);
            sw           = pattern;
            wait_for_reg($sformatf("rate_%0d_settle", rate), REG_SWITCHES,
                         bus_data_t'(pattern));
            write_reg(REG_TICK_COUNT, $urandom);
            repeat (RATE_CYCLES - 1) @(posedge clk);
            #1;
            read_reg(REG_TICK_COUNT, data);
            count    = int'(data);
            expected = RATE_CYCLES / divisor_for(rate_sel_t'(rate));
            assert (count >= expected - 1 && count <= expected + 1) else begin
                errors++;
                $display("error tick_rate_%0d: expected %0d, actual %0d",
                         rate, expected, count);
            end
        end

        for (int i = 0; i < 6; i++) begin
            value = hex_value_t'($urandom);
            blank = digit_mask_t'($urandom);
            dots  = digit_mask_t'($urandom);
            write_reg(REG_HEX_VALUE, bus_data_t'(value));
            write_reg(REG_HEX_CTRL, ctrl_word(blank, dots, '0));
            @(posedge clk);  // segments are registered.
            #1;
            check_display("display", value, blank, dots);
        end

        pattern      = sw;
        pattern[1:0] = 2'd0;  // fast tick.
        sw           = pattern;
        wait_for_reg("blink_settle", REG_SWITCHES, bus_data_t'(pattern));
        digit = $urandom_range(N_DIGITS - 1);
        value = hex_value_t'($urandom);
        dots  = digit_mask_t'($urandom);
        write_reg(REG_HEX_VALUE, bus_data_t'(value));
        write_reg(REG_HEX_CTRL, ctrl_word('0, dots, digit_mask_t'(1 << digit)));
        @(posedge clk);
        #1;
        prev        = hex_all[8*digit +: 8];
        changes     = 0;
        last_change = -1;
        for (int cyc = 0; cyc < BLINK_CYCLES; cyc++) begin
            @(posedge clk);
            #1;
            seg  = hex_all[8*digit +: 8];
            dark = (seg === 8'hFF) ? digit_mask_t'(1 << digit) : '0;
            check_display("blink", value, dark, dots);
            if (seg !== prev) begin
                if (last_change >= 0) begin
                    check_value("blink_interval", TICK_DIV_FAST, cyc - last_change);
                end
                changes++;
                last_change = cyc;
            end
            prev = seg;
        end
        assert (changes >= BLINK_CYCLES / TICK_DIV_FAST - 1) else begin
            errors++;
            $display("error blink_toggles: expected %0d, actual %0d",
                     BLINK_CYCLES / TICK_DIV_FAST, changes);
        end

        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/board_pkg.sv
source/bus_pkg.sv
source/display_if.sv
source/io_ctrl.sv
source/input_debouncer.sv
source/tick_divider.sv
source/hex_display.sv
source/de10_lite_io.sv
dv/tb_de10_lite_io.sv
